//--- verilog/board_pkg.sv
/*
  Register-bus types and offsets of the board register bank.
  Offsets are byte addresses; only the three listed offsets are mapped.
*/
package board_pkg;

  ////////////////////////////////////////////////////////////
  // Register bus
  ////////////////////////////////////////////////////////////

  // Byte address on the register bus
  typedef logic [7:0] reg_addr_t;

  // Data word for reads and writes
  typedef logic [31:0] reg_data_t;

  // Register offsets
  localparam reg_addr_t RegAddrLeds        = 8'h00;
  localparam reg_addr_t RegAddrFanCtl      = 8'h04;
  localparam reg_addr_t RegAddrFanOverride = 8'h08;

  ////////////////////////////////////////////////////////////
  // Fan
  ////////////////////////////////////////////////////////////

  // Fan speed setting, 0 is off and 15 is nearly full
  typedef logic [3:0] fan_level_t;

  // PWM steps in one fan period, one per level value
  localparam int unsigned FanSteps = 16;

endpackage

//--- verilog/pad_pkg.sv
/*
  SPI pad types shared by the top level and the SD pad mux.
  Chip selects are active low, one per attached device.
*/
package pad_pkg;

  // Four SPI data lines, line 0 is MOSI in single mode
  typedef logic [3:0] spi_data_t;

  // Active-low chip selects
  typedef logic [1:0] spi_cs_t;

  // Chip-select index of each device
  localparam int unsigned SpiCsSd    = 0;
  localparam int unsigned SpiCsFlash = 1;

  // SD lines float high when not driven by the SoC
  localparam logic PadIdleLevel = 1'b1;

endpackage

//--- verilog/board_cfg_regs.sv
/*
  Board register bank behind a single-cycle strobe bus, response one cycle later.
  NumLeds must be 1 to 32. Fan level follows fan_sw_i unless override is set.
*/
module board_cfg_regs #(
  parameter int unsigned NumLeds = 8
) (
  input  logic                  soc_clk,
  input  logic                  rst_n,
  input  logic                  req_valid_i,
  input  logic                  req_write_i,
  input  board_pkg::reg_addr_t  req_addr_i,
  input  board_pkg::reg_data_t  req_wdata_i,
  output logic                  rsp_valid_o,
  output board_pkg::reg_data_t  rsp_rdata_o,
  output logic                  rsp_error_o,
  input  board_pkg::fan_level_t fan_sw_i,
  output logic [NumLeds-1:0]    led_o,
  output board_pkg::fan_level_t fan_level_o
);
  import board_pkg::*;

  logic [NumLeds-1:0] led_q;
  fan_level_t         fan_level_q;
  logic               override_q;

  logic               rsp_valid_q;
  logic               rsp_error_q;
  reg_data_t          rsp_rdata_q;

  logic               addr_hit;
  reg_data_t          read_data;
  logic               wr_req;

  ////////////////////////////////////////////////////////////
  // Address decode and read mux
  ////////////////////////////////////////////////////////////

  always_comb begin
    addr_hit  = 1'b1;
    read_data = '0;
    case (req_addr_i)
      RegAddrLeds:        read_data = reg_data_t'(led_q);
      RegAddrFanCtl:      read_data = reg_data_t'(fan_level_q);
      RegAddrFanOverride: read_data = reg_data_t'(override_q);
      default:            addr_hit  = 1'b0;
    endcase
  end

  assign wr_req = req_valid_i & req_write_i;

  ////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge soc_clk, negedge rst_n) begin
    if (!rst_n) begin
      led_q       <= '0;
      fan_level_q <= '0;
      override_q  <= 1'b0;
    end else begin
      if (wr_req && req_addr_i == RegAddrLeds) begin
        led_q <= req_wdata_i[NumLeds-1:0];
      end
      if (wr_req && req_addr_i == RegAddrFanOverride) begin
        override_q <= req_wdata_i[0];
      end
      // Switches win while override is clear, bus writes are dropped
      if (!override_q) begin
        fan_level_q <= fan_sw_i;
      end else if (wr_req && req_addr_i == RegAddrFanCtl) begin
        fan_level_q <= req_wdata_i[$bits(fan_level_t)-1:0];
      end
    end
  end

  // Response strobe and status
  always_ff @(posedge soc_clk, negedge rst_n) begin
    if (!rst_n) begin
      rsp_valid_q <= 1'b0;
      rsp_error_q <= 1'b0;
    end else begin
      rsp_valid_q <= req_valid_i;
      rsp_error_q <= req_valid_i & ~addr_hit;
    end
  end

  // Read data is zero for writes and unmapped addresses
  always_ff @(posedge soc_clk) begin
    if (req_valid_i) begin
      rsp_rdata_q <= req_write_i ? '0 : read_data;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_error_o = rsp_error_q;
  assign rsp_rdata_o = rsp_rdata_q;
  assign led_o       = led_q;
  assign fan_level_o = fan_level_q;

endmodule

//--- verilog/fan_pwm.sv
/*
  Fan PWM with FanSteps steps of FanPrescale cycles each, output registered.
  Duty is level/FanSteps; a new level applies within one period.
*/
module fan_pwm #(
  parameter int unsigned FanPrescale = 64
) (
  input  logic                  soc_clk,
  input  logic                  rst_n,
  input  board_pkg::fan_level_t fan_level_i,
  output logic                  fan_pwm_o
);
  import board_pkg::*;

  localparam int unsigned PreWidth = (FanPrescale > 1) ? $clog2(FanPrescale) : 1;

  logic [PreWidth-1:0] pre_q;
  fan_level_t          step_q;
  logic                step_tick;
  logic                pwm_q;

  // Prescaler, one tick per step
  assign step_tick = (pre_q == PreWidth'(FanPrescale - 1));

  always_ff @(posedge soc_clk, negedge rst_n) begin
    if (!rst_n) begin
      pre_q <= '0;
    end else if (step_tick) begin
      pre_q <= '0;
    end else begin
      pre_q <= pre_q + 1'b1;
    end
  end

  // Step counter runs through one PWM period
  always_ff @(posedge soc_clk, negedge rst_n) begin
    if (!rst_n) begin
      step_q <= '0;
    end else if (step_tick) begin
      if (step_q == fan_level_t'(FanSteps - 1)) begin
        step_q <= '0;
      end else begin
        step_q <= step_q + 1'b1;
      end
    end
  end

  // High for the first level steps of every period
  always_ff @(posedge soc_clk, negedge rst_n) begin
    if (!rst_n) begin
      pwm_q <= 1'b0;
    end else begin
      pwm_q <= (step_q < fan_level_i);
    end
  end

  assign fan_pwm_o = pwm_q;

endmodule

//--- verilog/rtc_divider.sv
/*
  Slow RTC level from soc_clk, one period every RtcDivide cycles.
  RtcDivide must be even and at least 2.
*/
module rtc_divider #(
  parameter int unsigned RtcDivide = 50
) (
  input  logic soc_clk,
  input  logic rst_n,
  output logic rtc_o
);

  localparam int unsigned HalfDivide = RtcDivide / 2;
  localparam int unsigned CntWidth   = (HalfDivide > 1) ? $clog2(HalfDivide) : 1;

  logic [CntWidth-1:0] cnt_q;
  logic                half_done;
  logic                rtc_q;

  assign half_done = (cnt_q == CntWidth'(HalfDivide - 1));

  // Toggle once per half period
  always_ff @(posedge soc_clk, negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
      rtc_q <= 1'b0;
    end else if (half_done) begin
      cnt_q <= '0;
      rtc_q <= ~rtc_q;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign rtc_o = rtc_q;

endmodule

//--- verilog/spi_sd_pad_mux.sv
/*
  SD card pins in SPI mode, idle high when the SoC does not drive them.
  Purely combinational. Only data line 0 goes to the card as MOSI.
*/
module spi_sd_pad_mux (
  input  logic               spi_sck_i,
  input  logic               spi_sck_en_i,
  input  pad_pkg::spi_cs_t   spi_csb_i,
  input  pad_pkg::spi_cs_t   spi_csb_en_i,
  input  pad_pkg::spi_data_t spi_sd_out_i,
  input  pad_pkg::spi_data_t spi_sd_en_i,
  input  logic               sd_dat0_i,
  input  pad_pkg::spi_data_t flash_sd_i,
  output pad_pkg::spi_data_t spi_sd_o,
  output logic               sd_sclk_o,
  output logic               sd_cmd_o,
  output logic               sd_dat3_o
);
  import pad_pkg::*;

  localparam int unsigned DataWidth = $bits(spi_data_t);

  spi_data_t sd_in;
  spi_data_t sd_sel_mask;
  spi_data_t flash_sel_mask;

  ////////////////////////////////////////////////////////////
  // Card side
  ////////////////////////////////////////////////////////////

  // SD CLK
  assign sd_sclk_o = spi_sck_en_i ? spi_sck_i : PadIdleLevel;

  // DAT3 doubles as chip select in SPI mode
  assign sd_dat3_o = spi_csb_en_i[SpiCsSd] ? spi_csb_i[SpiCsSd] : PadIdleLevel;

  // CMD carries MOSI
  assign sd_cmd_o = spi_sd_en_i[0] ? spi_sd_out_i[0] : PadIdleLevel;

  ////////////////////////////////////////////////////////////
  // SoC side
  ////////////////////////////////////////////////////////////

  // MISO from DAT0 arrives on line 1, like a standard SPI host expects
  always_comb begin
    sd_in    = '0;
    sd_in[1] = sd_dat0_i;
  end

  // Only the selected device may return data
  assign sd_sel_mask    = {DataWidth{~spi_csb_i[SpiCsSd]}};
  assign flash_sel_mask = {DataWidth{~spi_csb_i[SpiCsFlash]}};

  assign spi_sd_o = (sd_sel_mask & sd_in) | (flash_sel_mask & flash_sd_i);

endmodule

//--- verilog/board_periph_top.sv
/*
  Board peripherals around the SoC: config registers, fan PWM, RTC and SD pads.
  rst_n must already be synchronous to soc_clk. Tristates stay as value/enable pairs.
*/
module board_periph_top #(
  parameter int unsigned NumLeds     = 8,
  parameter int unsigned RtcDivide   = 50,
  parameter int unsigned FanPrescale = 64
) (
  input  logic                  soc_clk,
  input  logic                  rst_n,
  // Register bus
  input  logic                  req_valid_i,
  input  logic                  req_write_i,
  input  board_pkg::reg_addr_t  req_addr_i,
  input  board_pkg::reg_data_t  req_wdata_i,
  output logic                  rsp_valid_o,
  output board_pkg::reg_data_t  rsp_rdata_o,
  output logic                  rsp_error_o,
  // Board I/O
  output logic [NumLeds-1:0]    led_o,
  input  board_pkg::fan_level_t fan_sw_i,
  output logic                  fan_pwm_o,
  output logic                  rtc_o,
  // SoC SPI host side
  input  logic                  spi_sck_i,
  input  logic                  spi_sck_en_i,
  input  pad_pkg::spi_cs_t      spi_csb_i,
  input  pad_pkg::spi_cs_t      spi_csb_en_i,
  input  pad_pkg::spi_data_t    spi_sd_out_i,
  input  pad_pkg::spi_data_t    spi_sd_en_i,
  output pad_pkg::spi_data_t    spi_sd_o,
  // SD card and flash pins
  input  logic                  sd_dat0_i,
  input  pad_pkg::spi_data_t    flash_sd_i,
  output logic                  sd_sclk_o,
  output logic                  sd_cmd_o,
  output logic                  sd_dat3_o
);
  import board_pkg::*;

  fan_level_t fan_level;

  ////////////////////////////////////////////////////////////
  // Config registers
  ////////////////////////////////////////////////////////////

  board_cfg_regs #(
    .NumLeds ( NumLeds )
  ) i_board_cfg_regs (
    .soc_clk     ( soc_clk     ),
    .rst_n       ( rst_n       ),
    .req_valid_i ( req_valid_i ),
    .req_write_i ( req_write_i ),
    .req_addr_i  ( req_addr_i  ),
    .req_wdata_i ( req_wdata_i ),
    .rsp_valid_o ( rsp_valid_o ),
    .rsp_rdata_o ( rsp_rdata_o ),
    .rsp_error_o ( rsp_error_o ),
    .fan_sw_i    ( fan_sw_i    ),
    .led_o       ( led_o       ),
    .fan_level_o ( fan_level   )
  );

  ////////////////////////////////////////////////////////////
  // Fan and RTC
  ////////////////////////////////////////////////////////////

  fan_pwm #(
    .FanPrescale ( FanPrescale )
  ) i_fan_pwm (
    .soc_clk     ( soc_clk   ),
    .rst_n       ( rst_n     ),
    .fan_level_i ( fan_level ),
    .fan_pwm_o   ( fan_pwm_o )
  );

  rtc_divider #(
    .RtcDivide ( RtcDivide )
  ) i_rtc_divider (
    .soc_clk ( soc_clk ),
    .rst_n   ( rst_n   ),
    .rtc_o   ( rtc_o   )
  );

  ////////////////////////////////////////////////////////////
  // SPI to SD
  ////////////////////////////////////////////////////////////

  spi_sd_pad_mux i_spi_sd_pad_mux (
    .spi_sck_i    ( spi_sck_i    ),
    .spi_sck_en_i ( spi_sck_en_i ),
    .spi_csb_i    ( spi_csb_i    ),
    .spi_csb_en_i ( spi_csb_en_i ),
    .spi_sd_out_i ( spi_sd_out_i ),
    .spi_sd_en_i  ( spi_sd_en_i  ),
    .sd_dat0_i    ( sd_dat0_i    ),
    .flash_sd_i   ( flash_sd_i   ),
    .spi_sd_o     ( spi_sd_o     ),
    .sd_sclk_o    ( sd_sclk_o    ),
    .sd_cmd_o     ( sd_cmd_o     ),
    .sd_dat3_o    ( sd_dat3_o    )
  );

endmodule

//--- test/tb_clock_gen.sv
/*
  soc_clk source and reset for the testbench. Reset is held low for
  ResetCycles rising edges and released on a falling edge.
*/
module tb_clock_gen #(
  parameter int unsigned Period      = 8,
  parameter int unsigned ResetCycles = 2
) (
  output logic soc_clk,
  output logic rst_n
);

  initial begin
    soc_clk = 1'b0;
    forever #(Period / 2) soc_clk = ~soc_clk;
  end

  // Release away from the sampling point after the rising edge
  initial begin
    rst_n = 1'b0;
    repeat (ResetCycles) @(posedge soc_clk);
    @(negedge soc_clk);
    rst_n = 1'b1;
  end

endmodule

//--- test/board_periph_checker.sv
/*
  Compares DUT outputs with expected values and counts failures per test.
  Samples 1 time unit after the rising edge, where outputs have settled.
*/
module board_periph_checker #(
  parameter int unsigned NumLeds   = 8,
  parameter int unsigned PwmWindow = 32
) (
  input  logic                 soc_clk,
  input  logic                 rsp_valid_i,
  input  board_pkg::reg_data_t rsp_rdata_i,
  input  logic                 rsp_error_i,
  input  logic [NumLeds-1:0]   led_i,
  input  logic                 fan_pwm_i,
  input  logic                 rtc_i,
  input  pad_pkg::spi_data_t   spi_sd_i,
  input  logic                 sd_sclk_i,
  input  logic                 sd_cmd_i,
  input  logic                 sd_dat3_i,
  output int                   tests_run_o,
  output int                   tests_failed_o,
  output int                   check_errs_o
);

  localparam int unsigned RtcTimeout = 200;

  int row_errs;

  initial begin
    row_errs       = 0;
    tests_run_o    = 0;
    tests_failed_o = 0;
    check_errs_o   = 0;
  end

  function automatic void compare(input string what, input logic [31:0] got,
                                  input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAILED at %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
      row_errs++;
      check_errs_o++;
    end
  endfunction

  function automatic void report_timeout(input string what);
    $display("timeout at %0t while waiting for %s", $time, what);
    row_errs++;
    check_errs_o++;
  endfunction

  task automatic verify_response(input int unsigned late_cycles, input logic [31:0] exp_data,
                                 input logic exp_err, input logic led_chk,
                                 input logic [NumLeds-1:0] exp_led);
    compare("rsp_valid_o extra delay", late_cycles, 32'd0);
    compare("rsp_rdata_o", rsp_rdata_i, exp_data);
    compare("rsp_error_o", 32'(rsp_error_i), 32'(exp_err));
    if (led_chk) begin
      compare("led_o", 32'(led_i), 32'(exp_led));
    end
  endtask

  // Strobe lasts a single cycle
  task automatic verify_rsp_end();
    compare("rsp_valid_o after the response cycle", 32'(rsp_valid_i), 32'd0);
  endtask

  // Expected layout is {dat3, cmd, sclk, spi_sd[3:0]}
  task automatic verify_pads(input logic [6:0] exp);
    compare("spi_sd_o", 32'(spi_sd_i), 32'(exp[3:0]));
    compare("sd_sclk_o", 32'(sd_sclk_i), 32'(exp[4]));
    compare("sd_cmd_o", 32'(sd_cmd_i), 32'(exp[5]));
    compare("sd_dat3_o", 32'(sd_dat3_i), 32'(exp[6]));
  endtask

  ////////////////////////////////////////////////////////////
  // Measurements
  ////////////////////////////////////////////////////////////

  task automatic measure_pwm(input logic [31:0] exp_high);
    int unsigned high;
    high = 0;
    // One full period to settle after a level change
    repeat (PwmWindow) begin
      @(posedge soc_clk);
      #1;
    end
    repeat (PwmWindow) begin
      @(posedge soc_clk);
      #1;
      if (fan_pwm_i) begin
        high++;
      end
    end
    compare("fan_pwm_o high cycles", high, exp_high);
  endtask

  task automatic wait_rtc_rise(output int unsigned cycles, output bit seen);
    logic prev;
    prev   = rtc_i;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < RtcTimeout) begin
      @(posedge soc_clk);
      #1;
      cycles++;
      seen = !prev && rtc_i;
      prev = rtc_i;
    end
    if (!seen) begin
      report_timeout("a rising edge of rtc_o");
    end
  endtask

  task automatic measure_rtc(input int unsigned periods, input int unsigned exp_interval);
    int unsigned cycles;
    bit          seen;
    // First edge only aligns the count
    wait_rtc_rise(cycles, seen);
    for (int unsigned p = 0; p < periods && seen; p++) begin
      wait_rtc_rise(cycles, seen);
      if (seen) begin
        compare("rtc_o rise interval", cycles, exp_interval);
      end
    end
  endtask

  task automatic close_test(input int idx, input string label);
    tests_run_o++;
    if (row_errs != 0) begin
      tests_failed_o++;
    end
    $display("test %0d %s: %s", idx, label, (row_errs == 0) ? "ok" : "mismatch");
    row_errs = 0;
  endtask

endmodule

//--- test/board_periph_tb.sv
/*
  Testbench for board_periph_top, run from a table of rows applied in order.
  Inputs change 1 time unit after the rising edge. Pad outputs are checked 1 unit later.
*/
module board_periph_tb;
  import board_pkg::*;
  import pad_pkg::*;

  localparam int unsigned NumLeds     = 8;
  localparam int unsigned RtcDivide   = 10;
  localparam int unsigned FanPrescale = 2;
  localparam int unsigned RspTimeout  = 20;
  localparam int unsigned NumRows     = 32;

  typedef enum logic [2:0] {
    OpWrite, OpRead, OpSwitch, OpPwm, OpRtc, OpPad, OpPadRandom
  } op_e;

  typedef struct packed {
    op_e                op;
    reg_addr_t          addr;
    reg_data_t          data;     // Write data, switches, RTC periods or pad vector
    reg_data_t          exp;      // Read data, high cycles, RTC interval or pad outputs
    logic               exp_err;
    logic               led_chk;
    logic [NumLeds-1:0] exp_led;
  } row_t;

  logic               soc_clk, rst_n;
  logic               req_valid_i, req_write_i;
  reg_addr_t          req_addr_i;
  reg_data_t          req_wdata_i, rsp_rdata_o;
  logic               rsp_valid_o, rsp_error_o;
  logic [NumLeds-1:0] led_o;
  fan_level_t         fan_sw_i;
  logic               fan_pwm_o, rtc_o;
  logic               spi_sck_i, spi_sck_en_i, sd_dat0_i;
  spi_cs_t            spi_csb_i, spi_csb_en_i;
  spi_data_t          spi_sd_out_i, spi_sd_en_i, spi_sd_o, flash_sd_i;
  logic               sd_sclk_o, sd_cmd_o, sd_dat3_o;
  int                 tests_run, tests_failed, check_errs;
  int                 seed = 32'hce36;

  // Pad vector bits: 0 sck, 1 sck_en, 3:2 csb, 5:4 csb_en, 9:6 sd_out,
  // 13:10 sd_en, 14 dat0, 18:15 flash data
  row_t rows [NumRows] = '{
    '{OpWrite,  RegAddrLeds,        32'h0000_00a5, 32'h00, 1'b0, 1'b1, 8'ha5},
    '{OpRead,   RegAddrLeds,        32'h0,         32'ha5, 1'b0, 1'b1, 8'ha5},
    '{OpWrite,  RegAddrLeds,        32'h1234_5f3c, 32'h00, 1'b0, 1'b1, 8'h3c},
    '{OpRead,   RegAddrLeds,        32'h0,         32'h3c, 1'b0, 1'b1, 8'h3c},
    '{OpWrite,  RegAddrFanOverride, 32'hffff_fffe, 32'h00, 1'b0, 1'b0, 8'h00},
    '{OpRead,   RegAddrFanOverride, 32'h0,         32'h00, 1'b0, 1'b0, 8'h00},
    '{OpWrite,  8'h0c,              32'h0000_00ff, 32'h00, 1'b1, 1'b1, 8'h3c},
    '{OpRead,   8'h0c,              32'h0,         32'h00, 1'b1, 1'b1, 8'h3c},
    '{OpRead,   RegAddrLeds,        32'h0,         32'h3c, 1'b0, 1'b1, 8'h3c},
    '{OpRead,   RegAddrFanOverride, 32'h0,         32'h00, 1'b0, 1'b0, 8'h00},
    '{OpSwitch, 8'h00,              32'h9,         32'h00, 1'b0, 1'b0, 8'h00},
    '{OpRead,   RegAddrFanCtl,      32'h0,         32'h09, 1'b0, 1'b0, 8'h00},
    '{OpWrite,  RegAddrFanCtl,      32'h3,         32'h00, 1'b0, 1'b0, 8'h00},
    '{OpRead,   RegAddrFanCtl,      32'h0,         32'h09, 1'b0, 1'b0, 8'h00},
    '{OpPwm,    8'h00,              32'h0,         32'd18, 1'b0, 1'b0, 8'h00},
    '{OpWrite,  RegAddrFanOverride, 32'h1,         32'h00, 1'b0, 1'b0, 8'h00},
    '{OpRead,   RegAddrFanOverride, 32'h0,         32'h01, 1'b0, 1'b0, 8'h00},
    '{OpWrite,  RegAddrFanCtl,      32'h25,        32'h00, 1'b0, 1'b0, 8'h00},
    '{OpSwitch, 8'h00,              32'hc,         32'h00, 1'b0, 1'b0, 8'h00},
    '{OpRead,   RegAddrFanCtl,      32'h0,         32'h05, 1'b0, 1'b0, 8'h00},
    '{OpPwm,    8'h00,              32'h0,         32'd10, 1'b0, 1'b0, 8'h00},
    '{OpWrite,  RegAddrFanCtl,      32'h0,         32'h00, 1'b0, 1'b0, 8'h00},
    '{OpPwm,    8'h00,              32'h0,         32'd0,  1'b0, 1'b0, 8'h00},
    '{OpWrite,  RegAddrFanCtl,      32'hf,         32'h00, 1'b0, 1'b0, 8'h00},
    '{OpRead,   RegAddrFanCtl,      32'h0,         32'h0f, 1'b0, 1'b0, 8'h00},
    '{OpPwm,    8'h00,              32'h0,         32'd30, 1'b0, 1'b0, 8'h00},
    '{OpRtc,    8'h00,              32'd4,         32'd10, 1'b0, 1'b0, 8'h00},
    '{OpPad,    8'h00,              32'h0007_c3cc, 32'h70, 1'b0, 1'b0, 8'h00},
    '{OpPad,    8'h00,              32'h0007_c41a, 32'h02, 1'b0, 1'b0, 8'h00},
    '{OpPad,    8'h00,              32'h0005_4477, 32'h7a, 1'b0, 1'b0, 8'h00},
    '{OpPad,    8'h00,              32'h0002_4001, 32'h76, 1'b0, 1'b0, 8'h00},
    '{OpPadRandom, 8'h00,           32'd24,        32'h00, 1'b0, 1'b0, 8'h00}
  };

  tb_clock_gen #(.Period(8), .ResetCycles(2)) clk_gen_i (.soc_clk(soc_clk), .rst_n(rst_n));

  board_periph_top #(
    .NumLeds(NumLeds), .RtcDivide(RtcDivide), .FanPrescale(FanPrescale)
  ) dut_i (.*);

  board_periph_checker #(.NumLeds(NumLeds), .PwmWindow(FanSteps * FanPrescale)) chk_i (
    .soc_clk(soc_clk), .rsp_valid_i(rsp_valid_o), .rsp_rdata_i(rsp_rdata_o),
    .rsp_error_i(rsp_error_o), .led_i(led_o), .fan_pwm_i(fan_pwm_o), .rtc_i(rtc_o),
    .spi_sd_i(spi_sd_o), .sd_sclk_i(sd_sclk_o), .sd_cmd_i(sd_cmd_o), .sd_dat3_i(sd_dat3_o),
    .tests_run_o(tests_run), .tests_failed_o(tests_failed), .check_errs_o(check_errs)
  );

  ////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////

  task automatic bus_access(input row_t r);
    int unsigned waited;
    waited      = 0;
    req_valid_i = 1'b1;
    req_write_i = (r.op == OpWrite);
    req_addr_i  = r.addr;
    req_wdata_i = r.data;
    @(posedge soc_clk);
    #1;
    req_valid_i = 1'b0;
    while (!rsp_valid_o && waited < RspTimeout) begin
      @(posedge soc_clk);
      #1;
      waited++;
    end
    if (rsp_valid_o) begin
      chk_i.verify_response(waited, r.exp, r.exp_err, r.led_chk, r.exp_led);
      @(posedge soc_clk);
      #1;
      chk_i.verify_rsp_end();
    end else begin
      chk_i.report_timeout("rsp_valid_o after a bus request");
    end
  endtask

  task automatic drive_pad(input logic [18:0] v);
    spi_sck_i    = v[0];
    spi_sck_en_i = v[1];
    spi_csb_i    = v[3:2];
    spi_csb_en_i = v[5:4];
    spi_sd_out_i = v[9:6];
    spi_sd_en_i  = v[13:10];
    sd_dat0_i    = v[14];
    flash_sd_i   = v[18:15];
  endtask

  // Expected {dat3, cmd, sclk, spi_sd} from the SD pad rules
  function automatic logic [6:0] pad_rule(input logic [18:0] v);
    logic [3:0] sd_vec;
    logic [3:0] spi;
    sd_vec   = {2'b00, v[14], 1'b0};
    spi      = (v[2] ? 4'h0 : sd_vec) | (v[3] ? 4'h0 : v[18:15]);
    pad_rule = {(v[4] ? v[2] : 1'b1), (v[10] ? v[6] : 1'b1), (v[1] ? v[0] : 1'b1), spi};
  endfunction

  task automatic apply_pad(input logic [18:0] v, input logic [6:0] exp);
    drive_pad(v);
    #1;
    chk_i.verify_pads(exp);
    @(posedge soc_clk);
    #1;
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int unsigned waited;
    logic [18:0] vec;
    op_e         op;
    waited      = 0;
    req_valid_i = 1'b0;
    req_write_i = 1'b0;
    req_addr_i  = '0;
    req_wdata_i = '0;
    fan_sw_i    = '0;
    drive_pad('0);
    while (rst_n !== 1'b1 && waited < 10) begin
      @(posedge soc_clk);
      #1;
      waited++;
    end
    if (rst_n !== 1'b1) begin
      chk_i.report_timeout("reset release");
    end
    for (int i = 0; i < NumRows; i++) begin
      op = rows[i].op;
      case (op)
        OpWrite, OpRead: bus_access(rows[i]);
        OpSwitch: begin
          fan_sw_i = fan_level_t'(rows[i].data);
          repeat (3) begin
            @(posedge soc_clk);
            #1;
          end
        end
        OpPwm:   chk_i.measure_pwm(rows[i].exp);
        OpRtc:   chk_i.measure_rtc(rows[i].data, rows[i].exp);
        OpPad:   apply_pad(rows[i].data[18:0], rows[i].exp[6:0]);
        default: begin
          for (int n = 0; n < rows[i].data; n++) begin
            vec = 19'($random(seed));
            apply_pad(vec, pad_rule(vec));
          end
        end
      endcase
      chk_i.close_test(i, op.name());
    end
    $display("tests run %0d, tests failed %0d, failed checks %0d",
             tests_run, tests_failed, check_errs);
    if (tests_failed == 0 && check_errs == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- all.f
verilog/board_pkg.sv
verilog/pad_pkg.sv
verilog/board_cfg_regs.sv
verilog/fan_pwm.sv
verilog/rtc_divider.sv
verilog/spi_sd_pad_mux.sv
verilog/board_periph_top.sv
test/tb_clock_gen.sv
test/board_periph_checker.sv
test/board_periph_tb.sv

//--- Makefile
VERILATOR  ?= verilator
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing -j 0
TOP        := board_periph_tb
RTL_TOP    := board_periph_top
FILELIST   := all.f
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q '\*\* PASS \*\*' $(LOG); then echo "simulation incomplete"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
